//--- common/radio_io_defs.svh
`ifndef RADIO_IO_DEFS_SVH
`define RADIO_IO_DEFS_SVH

// Width of one I or Q sample on the CMOS bus
`define SAMPLE_W 12

// Transmit channel sets held in the buffer
// The baseband starts with this many credits after reset
`define TX_FIFO_DEPTH 4

// Flops in the mimo input synchronizer
`define MIMO_SYNC_STAGES 2

// Cycles both paths stay idle after a mode change
`define MODE_SETTLE_CYCLES 4

`endif

//--- common/radio_io_pkg.sv
`include "radio_io_defs.svh"

package radio_io_pkg;

  // One complex sample
  typedef struct packed {
    logic [`SAMPLE_W-1:0] q;
    logic [`SAMPLE_W-1:0] i;
  } iq_sample_t;

  // The two halves delivered by a DDR cell in one radio_clk cycle
  typedef struct packed {
    logic [`SAMPLE_W-1:0] rise;
    logic [`SAMPLE_W-1:0] fall;
  } ddr_half_t;

  // Rising half carries Q and falling half carries I
  typedef union packed {
    iq_sample_t iq;
    ddr_half_t  half;
  } pin_word_u;

  // Receive pins as seen after the input DDR cells
  typedef struct packed {
    pin_word_u word;
    logic      frame_rise;
    logic      frame_fall;
  } rx_pins_t;

  // Transmit pins as handed to the output DDR cells
  typedef struct packed {
    pin_word_u word;
    logic      frame_rise;
    logic      frame_fall;
  } tx_pins_t;

  // One sample per channel
  typedef struct packed {
    iq_sample_t ch0;
    iq_sample_t ch1;
  } chan_set_t;

endpackage

//--- hdl/radio_mode_ctrl.sv
`timescale 1ns/1ps
`include "radio_io_defs.svh"

module radio_mode_ctrl (
  input  logic radio_clk,
  input  logic radio_rst,
  input  logic mimo_i,
  output logic mimo_mode_o,
  output logic restart_o,
  output logic busy_o
);

  localparam int SYNC_STAGES = `MIMO_SYNC_STAGES;
  localparam int SETTLE_W    = $clog2(`MODE_SETTLE_CYCLES + 1);

  logic [SYNC_STAGES-1:0] mimo_sync_q;
  logic                   mimo_synced;
  logic [SETTLE_W-1:0]    settle_cnt_q;

  assign mimo_synced = mimo_sync_q[SYNC_STAGES-1];
  assign busy_o      = (settle_cnt_q != '0);

  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      mimo_sync_q  <= '0;
      mimo_mode_o  <= 1'b0;
      restart_o    <= 1'b0;
      // Paths start idle out of reset as well
      settle_cnt_q <= SETTLE_W'(`MODE_SETTLE_CYCLES);
    end else begin
      mimo_sync_q <= {mimo_sync_q[SYNC_STAGES-2:0], mimo_i};
      restart_o   <= 1'b0;
      if (mimo_synced != mimo_mode_o) begin
        mimo_mode_o  <= mimo_synced;
        restart_o    <= 1'b1;
        settle_cnt_q <= SETTLE_W'(`MODE_SETTLE_CYCLES);
      end else if (settle_cnt_q != '0) begin
        settle_cnt_q <= settle_cnt_q - 1'b1;
      end
    end
  end

  // Both paths rely on restart to realign whenever the mode moves
  a_mode_with_restart: assert property (@(posedge radio_clk) disable iff (radio_rst)
    $changed(mimo_mode_o) |-> (restart_o && busy_o
                               && (mimo_mode_o == $past(mimo_i, SYNC_STAGES + 1))))
    else $error("radio_mode_ctrl: mode changed without restart");

endmodule

//--- rx_capture/rx_deinterleave.sv
`timescale 1ns/1ps

module rx_deinterleave import radio_io_pkg::*; (
  input  logic      radio_clk,
  input  logic      radio_rst,
  input  rx_pins_t  rx_pins_i,
  input  logic      mimo_mode_i,
  input  logic      busy_i,
  output chan_set_t rx_set_o,
  output logic      rx_stb_o
);

  iq_sample_t rx_sample;

  // Read the word as pin halves and rebuild the sample
  always_comb begin
    rx_sample.q = rx_pins_i.word.half.rise;
    rx_sample.i = rx_pins_i.word.half.fall;
  end

  // Sample registers, steered by the frame bit in MIMO
  always_ff @(posedge radio_clk) begin
    if (mimo_mode_i) begin
      if (rx_pins_i.frame_rise) begin
        rx_set_o.ch0 <= rx_sample;
      end else begin
        rx_set_o.ch1 <= rx_sample;
      end
    end else begin
      // SISO copies every pair to both channels
      rx_set_o.ch0 <= rx_sample;
      rx_set_o.ch1 <= rx_sample;
    end
  end

  // Strobe marks a complete channel set
  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      rx_stb_o <= 1'b0;
    end else if (busy_i) begin
      rx_stb_o <= 1'b0;
    end else if (mimo_mode_i) begin
      // Set is complete once ch1 has landed
      rx_stb_o <= ~rx_pins_i.frame_rise;
    end else begin
      rx_stb_o <= 1'b1;
    end
  end

  // Transceiver must interleave ch0 and ch1 strictly once settled in MIMO
  a_frame_alternates: assert property (@(posedge radio_clk) disable iff (radio_rst)
    (mimo_mode_i && !busy_i) ##1 (mimo_mode_i && !busy_i)
    |-> (rx_pins_i.frame_rise != $past(rx_pins_i.frame_rise)))
    else $error("rx_deinterleave: frame_rise did not alternate in MIMO");

endmodule

//--- tx_framer/tx_sample_fifo.sv
`timescale 1ns/1ps
`include "radio_io_defs.svh"

module tx_sample_fifo import radio_io_pkg::*; (
  input  logic      radio_clk,
  input  logic      radio_rst,
  input  logic      push_i,
  input  chan_set_t push_set_i,
  input  logic      pop_i,
  output chan_set_t head_o,
  output logic      empty_o,
  output logic      credit_o
);

  localparam int DEPTH = `TX_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  chan_set_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;

  // Wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign head_o  = mem[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full    = (count_q == CNT_W'(DEPTH));

  always_ff @(posedge radio_clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_set_i;
    end
  end

  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      // Each pop hands one credit back to the baseband
      credit_o <= pop_i;
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Baseband credit accounting keeps pushes within the free space
  a_no_push_full: assert property (@(posedge radio_clk) disable iff (radio_rst)
    push_i |-> !full)
    else $error("tx_sample_fifo: push into full buffer");

  a_no_pop_empty: assert property (@(posedge radio_clk) disable iff (radio_rst)
    pop_i |-> !empty_o)
    else $error("tx_sample_fifo: pop from empty buffer");

endmodule

//--- tx_framer/tx_interleave.sv
`timescale 1ns/1ps

module tx_interleave import radio_io_pkg::*; (
  input  logic      radio_clk,
  input  logic      radio_rst,
  input  logic      mimo_mode_i,
  input  logic      restart_i,
  input  logic      busy_i,
  input  chan_set_t head_i,
  input  logic      empty_i,
  output logic      pop_o,
  output tx_pins_t  tx_pins_o,
  output logic      underrun_o
);

  // Phase B sends the held ch1 in MIMO
  logic       phase_b_q;
  iq_sample_t ch1_hold_q;
  pin_word_u  tx_word_q;
  logic       frame_rise_q;
  logic       frame_fall_q;
  logic       pop_due;
  iq_sample_t siso_pick;

  // A new set is wanted every SISO cycle and every MIMO phase A
  assign pop_due = !busy_i && (!mimo_mode_i || !phase_b_q);
  assign pop_o   = pop_due && !empty_i;

  // SISO falls back to ch1 when ch0 is silent
  assign siso_pick = (head_i.ch0 != '0) ? head_i.ch0 : head_i.ch1;

  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      phase_b_q    <= 1'b0;
      frame_rise_q <= 1'b1;
      frame_fall_q <= 1'b0;
      underrun_o   <= 1'b0;
    end else begin
      underrun_o <= pop_due && empty_i;
      if (restart_i || busy_i) begin
        // Hold at phase A with its frame pattern
        phase_b_q    <= 1'b0;
        frame_rise_q <= 1'b1;
        frame_fall_q <= mimo_mode_i;
      end else if (mimo_mode_i) begin
        phase_b_q    <= ~phase_b_q;
        frame_rise_q <= ~phase_b_q;
        frame_fall_q <= ~phase_b_q;
      end else begin
        phase_b_q    <= 1'b0;
        frame_rise_q <= 1'b1;
        frame_fall_q <= 1'b0;
      end
    end
  end

  // Sample payload, encoded as a sample into the pin word
  always_ff @(posedge radio_clk) begin
    if (busy_i) begin
      tx_word_q.iq <= '0;
    end else if (mimo_mode_i && phase_b_q) begin
      tx_word_q.iq <= ch1_hold_q;
    end else if (empty_i) begin
      // Underrun sends silence on both MIMO phases
      tx_word_q.iq <= '0;
      ch1_hold_q   <= '0;
    end else if (mimo_mode_i) begin
      tx_word_q.iq <= head_i.ch0;
      ch1_hold_q   <= head_i.ch1;
    end else begin
      tx_word_q.iq <= siso_pick;
    end
  end

  always_comb begin
    tx_pins_o.word       = tx_word_q;
    tx_pins_o.frame_rise = frame_rise_q;
    tx_pins_o.frame_fall = frame_fall_q;
  end

endmodule

//--- hdl/radio_cmos_io.sv
`timescale 1ns/1ps

module radio_cmos_io import radio_io_pkg::*; (
  input  logic      radio_clk,
  input  logic      radio_rst,
  input  logic      mimo_i,
  // Receive side
  input  rx_pins_t  rx_pins_i,
  output chan_set_t rx_set_o,
  output logic      rx_stb_o,
  // Transmit side
  input  chan_set_t tx_set_i,
  input  logic      tx_valid_i,
  output logic      tx_credit_o,
  output tx_pins_t  tx_pins_o,
  output logic      tx_underrun_o
);

  logic      mimo_mode;
  logic      restart;
  logic      busy;
  chan_set_t tx_head;
  logic      tx_empty;
  logic      tx_pop;

  radio_mode_ctrl radio_mode_ctrl_i (
    .radio_clk   (radio_clk),
    .radio_rst   (radio_rst),
    .mimo_i      (mimo_i),
    .mimo_mode_o (mimo_mode),
    .restart_o   (restart),
    .busy_o      (busy)
  );

  rx_deinterleave rx_deinterleave_i (
    .radio_clk   (radio_clk),
    .radio_rst   (radio_rst),
    .rx_pins_i   (rx_pins_i),
    .mimo_mode_i (mimo_mode),
    .busy_i      (busy),
    .rx_set_o    (rx_set_o),
    .rx_stb_o    (rx_stb_o)
  );

  // Baseband pushes only against credits
  tx_sample_fifo tx_sample_fifo_i (
    .radio_clk  (radio_clk),
    .radio_rst  (radio_rst),
    .push_i     (tx_valid_i),
    .push_set_i (tx_set_i),
    .pop_i      (tx_pop),
    .head_o     (tx_head),
    .empty_o    (tx_empty),
    .credit_o   (tx_credit_o)
  );

  tx_interleave tx_interleave_i (
    .radio_clk   (radio_clk),
    .radio_rst   (radio_rst),
    .mimo_mode_i (mimo_mode),
    .restart_i   (restart),
    .busy_i      (busy),
    .head_i      (tx_head),
    .empty_i     (tx_empty),
    .pop_o       (tx_pop),
    .tx_pins_o   (tx_pins_o),
    .underrun_o  (tx_underrun_o)
  );

endmodule

//--- verification/tb_radio_checks.sv
`timescale 1ns/1ps
`include "radio_io_defs.svh"

module tb_radio_checks import radio_io_pkg::*; (
  input  logic      radio_clk,
  input  logic      radio_rst,
  input  logic      mimo_i,
  input  rx_pins_t  rx_pins_i,
  input  chan_set_t rx_set_i,
  input  logic      rx_stb_i,
  input  chan_set_t tx_set_i,
  input  logic      tx_valid_i,
  input  logic      tx_credit_i,
  input  tx_pins_t  tx_pins_i,
  input  logic      tx_underrun_i,
  output int        err_cnt_o
);

  localparam int DEPTH = `TX_FIFO_DEPTH;

  // Mode reference from mimo delayed through the sync stages and the settle window
  logic [`MIMO_SYNC_STAGES:0] mimo_dly_q;
  logic       mode_ref;
  logic       busy_ref;
  int         settle_q;
  // Inputs and mode as seen at the previous edge
  iq_sample_t prev_sample;
  logic       prev_fr;
  logic       prev_mode;
  logic       prev_busy;
  logic       stb_exp;
  // Buffer order model
  chan_set_t  model_q [256];
  logic [7:0] wr_idx_q;
  logic [7:0] rd_idx_q;
  chan_set_t  exp_set;
  iq_sample_t exp_pick;
  iq_sample_t exp_ch1_q;
  logic       phase_b_q;
  int         outstanding_q;
  int         e_rx = 0;
  int         e_stb = 0;
  int         e_pop = 0;
  int         e_phb = 0;
  int         e_idle = 0;
  int         e_und = 0;
  int         e_cred = 0;

  assign mode_ref  = mimo_dly_q[`MIMO_SYNC_STAGES];
  assign busy_ref  = (settle_q != 0);
  assign stb_exp   = prev_busy ? 1'b0 : (prev_mode ? !prev_fr : 1'b1);
  assign exp_set   = model_q[rd_idx_q];
  // SISO skips a silent ch0 while MIMO phase A always leads with ch0
  assign exp_pick  = (mode_ref || exp_set.ch0 != '0) ? exp_set.ch0 : exp_set.ch1;
  assign err_cnt_o = e_rx + e_stb + e_pop + e_phb + e_idle + e_und + e_cred;

  always @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      mimo_dly_q    <= '0;
      settle_q      <= `MODE_SETTLE_CYCLES;
      wr_idx_q      <= '0;
      rd_idx_q      <= '0;
      outstanding_q <= 0;
      phase_b_q     <= 1'b0;
    end else begin
      mimo_dly_q <= {mimo_dly_q[`MIMO_SYNC_STAGES-1:0], mimo_i};
      if (mimo_dly_q[`MIMO_SYNC_STAGES-1] != mode_ref) begin
        settle_q <= `MODE_SETTLE_CYCLES;
      end else if (busy_ref) begin
        settle_q <= settle_q - 1;
      end
      wr_idx_q      <= wr_idx_q + {7'd0, tx_valid_i};
      rd_idx_q      <= rd_idx_q + {7'd0, tx_credit_i};
      outstanding_q <= outstanding_q + int'(tx_valid_i) - int'(tx_credit_i);
      phase_b_q     <= tx_credit_i && mode_ref;
    end
  end

  always @(posedge radio_clk) begin
    prev_sample.q <= rx_pins_i.word.half.rise;
    prev_sample.i <= rx_pins_i.word.half.fall;
    prev_fr       <= rx_pins_i.frame_rise;
    prev_mode     <= mode_ref;
    prev_busy     <= busy_ref;
    exp_ch1_q     <= exp_set.ch1;
    if (tx_valid_i) begin
      model_q[wr_idx_q] <= tx_set_i;
    end
  end

  a_rx_set: assert property (@(posedge radio_clk) disable iff (radio_rst)
    (prev_mode ? (prev_fr ? rx_set_i.ch0 == prev_sample : rx_set_i.ch1 == prev_sample)
               : (rx_set_i.ch0 == prev_sample && rx_set_i.ch1 == prev_sample)))
    else begin
      e_rx++;
      $display("mismatch rx_set_o: got 0x%012h expected sample 0x%06h",
               $sampled(rx_set_i), $sampled(prev_sample));
    end

  a_rx_stb: assert property (@(posedge radio_clk) disable iff (radio_rst)
    rx_stb_i == stb_exp)
    else begin
      e_stb++;
      $display("mismatch rx_stb_o: got 0x%0h expected 0x%0h",
               $sampled(rx_stb_i), $sampled(stb_exp));
    end

  a_tx_pop: assert property (@(posedge radio_clk) disable iff (radio_rst)
    tx_credit_i |-> (tx_pins_i.word.iq == exp_pick && tx_pins_i.frame_rise
                     && tx_pins_i.frame_fall == mode_ref))
    else begin
      e_pop++;
      $display("mismatch tx_pins_o: got 0x%07h expected word 0x%06h",
               $sampled(tx_pins_i), $sampled(exp_pick));
    end

  a_tx_phase_b: assert property (@(posedge radio_clk) disable iff (radio_rst)
    phase_b_q |-> (tx_pins_i.word.iq == exp_ch1_q && !tx_pins_i.frame_rise
                   && !tx_pins_i.frame_fall))
    else begin
      e_phb++;
      $display("mismatch tx_pins_o: got 0x%07h expected ch1 0x%06h with frame 0x0",
               $sampled(tx_pins_i), $sampled(exp_ch1_q));
    end

  // Settle window sends silence with the phase A frame pattern
  a_tx_idle: assert property (@(posedge radio_clk) disable iff (radio_rst)
    prev_busy |-> (tx_pins_i.word.iq == '0 && tx_pins_i.frame_rise
                   && tx_pins_i.frame_fall == prev_mode))
    else begin
      e_idle++;
      $display("mismatch tx_pins_o: got 0x%07h expected zero word in settle window",
               $sampled(tx_pins_i));
    end

  a_tx_underrun: assert property (@(posedge radio_clk) disable iff (radio_rst)
    tx_underrun_i |-> (tx_pins_i.word.iq == '0 && !tx_credit_i))
    else begin
      e_und++;
      $display("mismatch tx_pins_o: got 0x%07h expected zero word on underrun",
               $sampled(tx_pins_i));
    end

  // More credits than sets sent drives the count below zero
  a_credit_bound: assert property (@(posedge radio_clk) disable iff (radio_rst)
    (outstanding_q >= 0) && (outstanding_q <= DEPTH))
    else begin
      e_cred++;
      $display("mismatch outstanding_sets: got 0x%0h expected 0x0 to 0x%0h",
               $sampled(outstanding_q), DEPTH);
    end

endmodule

//--- verification/tb_radio_cmos_io.sv
`timescale 1ns/1ps
`include "radio_io_defs.svh"

module tb_radio_cmos_io import radio_io_pkg::*; ();

  localparam int PERIOD      = 40;
  localparam int SW          = `SAMPLE_W;
  localparam int DEPTH       = `TX_FIFO_DEPTH;
  localparam int RX_LEN      = 40;
  localparam int TX_SETS     = 32;
  localparam int MODE_WAIT   = `MIMO_SYNC_STAGES + 1 + `MODE_SETTLE_CYCLES + 3;
  localparam int TEST_CYCLES = 3 + 2 * RX_LEN + 3 * (2 * TX_SETS + 20) + 2 * MODE_WAIT;

  logic      radio_clk;
  logic      radio_rst;
  logic      mimo_i;
  rx_pins_t  rx_pins_i;
  chan_set_t rx_set_o;
  logic      rx_stb_o;
  chan_set_t tx_set_i;
  logic      tx_valid_i;
  logic      tx_credit_o;
  tx_pins_t  tx_pins_o;
  logic      tx_underrun_o;

  int   seed = 78344;
  int   credits;
  int   sent;
  int   tb_errs;
  int   check_errs;
  int   err_base;
  int   tests_run;
  int   tests_failed;
  logic tx_send;
  logic frame_high;
  logic frame_tog;
  logic mimo_req;

  radio_cmos_io radio_cmos_io_i (
    .radio_clk     (radio_clk),
    .radio_rst     (radio_rst),
    .mimo_i        (mimo_i),
    .rx_pins_i     (rx_pins_i),
    .rx_set_o      (rx_set_o),
    .rx_stb_o      (rx_stb_o),
    .tx_set_i      (tx_set_i),
    .tx_valid_i    (tx_valid_i),
    .tx_credit_o   (tx_credit_o),
    .tx_pins_o     (tx_pins_o),
    .tx_underrun_o (tx_underrun_o)
  );

  tb_radio_checks checks_i (
    .radio_clk     (radio_clk),
    .radio_rst     (radio_rst),
    .mimo_i        (mimo_i),
    .rx_pins_i     (rx_pins_i),
    .rx_set_i      (rx_set_o),
    .rx_stb_i      (rx_stb_o),
    .tx_set_i      (tx_set_i),
    .tx_valid_i    (tx_valid_i),
    .tx_credit_i   (tx_credit_o),
    .tx_pins_i     (tx_pins_o),
    .tx_underrun_i (tx_underrun_o),
    .err_cnt_o     (check_errs)
  );

  initial begin
    radio_clk = 1'b0;
    forever #(PERIOD / 2) radio_clk = ~radio_clk;
  end

  // Pin and baseband stimulus with the credit counter on the baseband side
  always @(posedge radio_clk) begin : drive_inputs
    logic [31:0] rnd_a;
    logic [31:0] rnd_b;
    logic [31:0] rnd_c;
    rnd_a = $random(seed);
    rnd_b = $random(seed);
    rnd_c = $random(seed);
    frame_tog = ~frame_tog;
    rx_pins_i.word.half.rise <= rnd_a[SW-1:0];
    rx_pins_i.word.half.fall <= rnd_a[2*SW-1:SW];
    rx_pins_i.frame_rise     <= frame_high | frame_tog;
    rx_pins_i.frame_fall     <= frame_high ? 1'b0 : frame_tog;
    mimo_i <= mimo_req;
    if (radio_rst) begin
      credits = DEPTH;
      tx_valid_i <= 1'b0;
    end else begin
      if (tx_credit_o) begin
        credits = credits + 1;
      end
      if (tx_send && credits > 0) begin
        // About one set in four has a silent ch0
        tx_set_i.ch0 <= (rnd_b[1:0] == 2'b00) ? '0 : rnd_b[2*SW+1:2];
        tx_set_i.ch1 <= rnd_c[2*SW-1:0];
        tx_valid_i <= 1'b1;
        credits = credits - 1;
        sent = sent + 1;
      end else begin
        tx_valid_i <= 1'b0;
      end
    end
  end

  initial begin
    #(2 * TEST_CYCLES * PERIOD);
    $display("watchdog expired before all tests finished");
    $display("TESTS FAILED");
    $finish;
  end

  task automatic run_cycles(input int n);
    repeat (n) @(negedge radio_clk);
  endtask

  task automatic send_sets(input int n);
    int waited;
    waited = 0;
    sent = 0;
    tx_send = 1'b1;
    while (sent < n && waited < 4 * n + 20) begin
      @(negedge radio_clk);
      waited++;
    end
    tx_send = 1'b0;
    if (sent < n) begin
      $display("transmit stalled with only %0d of %0d sets accepted", sent, n);
      tb_errs++;
    end
  endtask

  task automatic drain_credits();
    int waited;
    waited = 0;
    while (credits != DEPTH && waited < 20) begin
      @(negedge radio_clk);
      waited++;
    end
    if (credits != DEPTH) begin
      $display("credits did not return to the buffer depth after draining");
      tb_errs++;
    end
  endtask

  // Each missed pop in a window of 8 cycles gives one underrun pulse
  task automatic count_underruns(input int expect_n);
    int cnt;
    cnt = 0;
    drain_credits();
    run_cycles(2);
    repeat (8) begin
      @(negedge radio_clk);
      cnt += int'(tx_underrun_o);
    end
    if (cnt != expect_n) begin
      $display("mismatch tx_underrun_o pulses: got 0x%0h expected 0x%0h", cnt, expect_n);
      tb_errs++;
    end
  endtask

  task automatic change_mode(input logic mode);
    drain_credits();
    mimo_req = mode;
    run_cycles(MODE_WAIT);
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = check_errs + tb_errs;
    tests_run++;
    if (errs > err_base) begin
      tests_failed++;
    end
    $display("test %s done with %0d errors", name, errs - err_base);
    err_base = errs;
  endtask

  initial begin
    radio_rst = 1'b1;
    mimo_i = 1'b0;
    rx_pins_i = '0;
    tx_set_i = '0;
    tx_valid_i = 1'b0;
    credits = 0;
    sent = 0;
    tb_errs = 0;
    err_base = 0;
    tests_run = 0;
    tests_failed = 0;
    tx_send = 1'b0;
    frame_high = 1'b1;
    frame_tog = 1'b0;
    mimo_req = 1'b0;
    repeat (3) @(posedge radio_clk);
    radio_rst <= 1'b0;
    run_cycles(2);
    run_cycles(RX_LEN);
    frame_high = 1'b0;
    finish_test("siso_receive");
    send_sets(TX_SETS);
    drain_credits();
    finish_test("siso_transmit");
    count_underruns(8);
    finish_test("siso_credit_underrun");
    change_mode(1'b1);
    finish_test("mode_change_to_mimo");
    run_cycles(RX_LEN);
    finish_test("mimo_receive");
    send_sets(TX_SETS);
    drain_credits();
    finish_test("mimo_transmit");
    count_underruns(4);
    finish_test("mimo_credit_underrun");
    change_mode(1'b0);
    send_sets(8);
    drain_credits();
    finish_test("mode_change_to_siso");
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_base);
    if (tests_failed == 0 && err_base == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+common
common/radio_io_pkg.sv
hdl/radio_mode_ctrl.sv
rx_capture/rx_deinterleave.sv
tx_framer/tx_sample_fifo.sv
tx_framer/tx_interleave.sv
hdl/radio_cmos_io.sv
verification/tb_radio_checks.sv
verification/tb_radio_cmos_io.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_radio_cmos_io
FLIST     := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FLIST)) $(wildcard common/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
